//--- common/rename_pkg.sv
// sizes and types for the rename core; num_pr must exceed num_arch, and num_arch tags stay busy at reset
package rename_pkg;

  // machine sizes
  localparam int num_arch = 8;   // architectural registers
  localparam int num_pr   = 16;  // physical registers
  localparam int num_rob  = 8;   // reorder buffer entries
  localparam int num_fu   = 2;   // functional units reading operands
  localparam int data_w   = 64;  // register width

  // derived widths
  localparam int arch_w    = $clog2(num_arch);
  localparam int tag_w     = $clog2(num_pr);
  localparam int rob_w     = $clog2(num_rob);
  localparam int rob_cnt_w = $clog2(num_rob + 1);  // count reaches num_rob itself

  typedef logic [arch_w-1:0]    arch_t;     // architectural register index
  typedef logic [tag_w-1:0]     tag_t;      // physical register tag
  typedef logic [rob_w-1:0]     rob_idx_t;  // reorder buffer slot
  typedef logic [rob_cnt_w-1:0] rob_cnt_t;  // occupancy, 0..num_rob
  typedef logic [data_w-1:0]    data_t;     // register value

  // one reorder buffer slot
  typedef struct packed {
    tag_t new_tag;  // tag given to the destination
    tag_t old_tag;  // previous mapping, freed at retire
  } rob_entry_t;

  // free bits out of reset
  // low num_arch tags hold the initial mapping
  localparam logic [num_pr-1:0] free_at_reset =
    {{(num_pr - num_arch){1'b1}}, {num_arch{1'b0}}};

  // identity mapping at reset: arch i -> tag i
  function automatic tag_t reset_map(input arch_t a);
    return tag_t'(a);
  endfunction

  // wrap-around increment for rob pointers
  function automatic rob_idx_t rob_next(input rob_idx_t p);
    if (p == rob_idx_t'(num_rob - 1)) begin
      return '0;
    end
    return p + rob_idx_t'(1);
  endfunction

endpackage

//--- pr_file/pr_file.sv
// value store and free list; a freed tag becomes allocatable the cycle after retire, bypass covers only same-cycle completion
`timescale 1ns/10ps

module pr_file (
  input  logic                                                clock,
  input  logic                                                reset,
  input  logic                                                dispatch_fire,
  input  logic                                                complete_valid,
  input  rename_pkg::tag_t                                    complete_tag,
  input  rename_pkg::data_t                                   complete_result,
  input  logic                                                retire,
  input  rename_pkg::tag_t                                    retire_old_tag,
  input  rename_pkg::tag_t  [rename_pkg::num_fu-1:0]          read_tag1,
  input  rename_pkg::tag_t  [rename_pkg::num_fu-1:0]          read_tag2,
  output rename_pkg::data_t [rename_pkg::num_fu-1:0]          read_value1,
  output rename_pkg::data_t [rename_pkg::num_fu-1:0]          read_value2,
  output rename_pkg::tag_t                                    alloc_tag,
  output logic                                                pr_full
);

  import rename_pkg::*;

  data_t             value [num_pr];  // register values
  logic [num_pr-1:0] free;            // 1 = tag available

  logic [num_pr-1:0] free_next;

  // lowest free tag
  // scan from the top so the lowest hit is written last
  always_comb begin
    alloc_tag = '0;
    for (int i = num_pr - 1; i >= 0; i--) begin
      if (free[i]) begin
        alloc_tag = tag_t'(i);
      end
    end
  end

  assign pr_full = ~|free;  // nothing left to hand out

  // operand reads
  always_comb begin
    for (int f = 0; f < num_fu; f++) begin
      // result on the writeback bus wins over the stored copy
      if (complete_valid && (complete_tag == read_tag1[f])) begin
        read_value1[f] = complete_result;  // bypass
      end else begin
        read_value1[f] = value[read_tag1[f]];
      end
      if (complete_valid && (complete_tag == read_tag2[f])) begin
        read_value2[f] = complete_result;  // bypass
      end else begin
        read_value2[f] = value[read_tag2[f]];
      end
    end
  end

  // free bit update
  // retire frees a busy tag, dispatch takes a free one, so they never collide
  always_comb begin
    free_next = free;
    if (retire) begin
      free_next[retire_old_tag] = 1'b1;  // old mapping released
    end
    if (dispatch_fire) begin
      free_next[alloc_tag] = 1'b0;       // claimed by new dest
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      free <= free_at_reset;
    end else begin
      free <= free_next;
    end
  end

  // value writeback
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_pr; i++) begin
        value[i] <= '0;  // all registers read zero out of reset
      end
    end else if (complete_valid) begin
      value[complete_tag] <= complete_result;
    end
  end

endmodule

//--- map_table/map_table.sv
// arch-to-physical map; lookups see the mapping from before this cycle's dispatch, no checkpoints
`timescale 1ns/10ps

module map_table (
  input  logic              clock,
  input  logic              reset,
  input  logic              dispatch_fire,
  input  rename_pkg::arch_t dest_arch,
  input  rename_pkg::arch_t src1_arch,
  input  rename_pkg::arch_t src2_arch,
  input  rename_pkg::tag_t  alloc_tag,
  output rename_pkg::tag_t  src1_tag,
  output rename_pkg::tag_t  src2_tag,
  output rename_pkg::tag_t  old_tag
);

  import rename_pkg::*;

  tag_t map [num_arch];  // current speculative map

  // lookups straight off the registered map
  // a source equal to dest still sees the old tag, the write lands at the edge
  assign src1_tag = map[src1_arch];
  assign src2_tag = map[src2_arch];
  assign old_tag  = map[dest_arch];  // goes to rob, freed when this inst retires

  // rename the destination
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_arch; i++) begin
        map[i] <= reset_map(arch_t'(i));  // identity
      end
    end else if (dispatch_fire) begin
      map[dest_arch] <= alloc_tag;        // newest producer of dest
    end
  end

endmodule

//--- reorder_buffer/reorder_buffer.sv
// in-order tag pair buffer; complete_rob must name a live entry, push and pop may share an edge
`timescale 1ns/10ps

module reorder_buffer (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 dispatch_fire,
  input  rename_pkg::tag_t     alloc_tag,
  input  rename_pkg::tag_t     old_tag,
  input  logic                 complete_valid,
  input  rename_pkg::rob_idx_t complete_rob,
  input  logic                 retire,
  output rename_pkg::rob_idx_t dispatch_rob,
  output rename_pkg::tag_t     retire_old_tag,
  output logic                 head_done,
  output logic                 rob_full
);

  import rename_pkg::*;

  rob_entry_t         entry [num_rob];  // tag pairs, no reset needed
  logic [num_rob-1:0] done;             // result written back

  rob_idx_t head;   // oldest in flight
  rob_idx_t tail;   // next free slot
  rob_cnt_t count;  // entries in flight

  logic empty;

  assign empty    = (count == '0);
  assign rob_full = (count == rob_cnt_t'(num_rob));

  // slot index goes back with the dispatch, used later as complete_rob
  assign dispatch_rob   = tail;
  assign retire_old_tag = entry[head].old_tag;
  assign head_done      = ~empty && done[head];  // oldest may leave

  // entry payload
  always_ff @(posedge clock) begin
    if (dispatch_fire) begin
      entry[tail].new_tag <= alloc_tag;
      entry[tail].old_tag <= old_tag;
    end
  end

  // done bits
  // a fresh slot starts not done, completion sets it
  always_ff @(posedge clock) begin
    if (reset) begin
      done <= '0;
    end else begin
      if (dispatch_fire) begin
        done[tail] <= 1'b0;
      end
      if (complete_valid) begin
        done[complete_rob] <= 1'b1;  // completions arrive in any order
      end
    end
  end

  // pointers
  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (dispatch_fire) begin
        tail <= rob_next(tail);
      end
      if (retire) begin
        head <= rob_next(head);  // pop in program order
      end
    end
  end

  // occupancy
  // push and pop together leave it unchanged
  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({dispatch_fire, retire})
        2'b10:   count <= count + rob_cnt_t'(1);
        2'b01:   count <= count - rob_cnt_t'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

//--- verilog/rename_control.sv
// dispatch accept and retire decision; combinational only, no state and no handshake beyond stall
`timescale 1ns/10ps

module rename_control (
  input  logic dispatch_valid,  // front end offers an instruction
  input  logic pr_full,         // no free physical tag
  input  logic rob_full,        // no free rob slot
  input  logic head_done,       // oldest entry has its result
  output logic stall,
  output logic dispatch_fire,
  output logic retire
);

  // either resource out means the dispatch has to wait
  // stall does not look at valid, the source sees it ahead of time
  assign stall = pr_full | rob_full;

  // single accept point, every block keys off this
  assign dispatch_fire = dispatch_valid & ~stall;

  // retire whenever the head is finished
  // one per cycle, nothing holds it back
  assign retire = head_done;

endmodule

//--- verilog/rename_top.sv
// rename core top; one dispatch, one completion and one retire per cycle, no flush on mispredict
`timescale 1ns/10ps

module rename_top (
  input  logic                                        clock,
  input  logic                                        reset,
  // dispatch
  input  logic                                        dispatch_valid,
  input  rename_pkg::arch_t                           dest_arch,
  input  rename_pkg::arch_t                           src1_arch,
  input  rename_pkg::arch_t                           src2_arch,
  // completion
  input  logic                                        complete_valid,
  input  rename_pkg::tag_t                            complete_tag,
  input  rename_pkg::rob_idx_t                        complete_rob,
  input  rename_pkg::data_t                           complete_result,
  // operand reads, one pair per unit
  input  rename_pkg::tag_t  [rename_pkg::num_fu-1:0]  read_tag1,
  input  rename_pkg::tag_t  [rename_pkg::num_fu-1:0]  read_tag2,
  output rename_pkg::data_t [rename_pkg::num_fu-1:0]  read_value1,
  output rename_pkg::data_t [rename_pkg::num_fu-1:0]  read_value2,
  // processor side results
  output logic                                        stall,
  output rename_pkg::tag_t                            alloc_tag,
  output rename_pkg::tag_t                            src1_tag,
  output rename_pkg::tag_t                            src2_tag,
  output rename_pkg::rob_idx_t                        dispatch_rob,
  output logic                                        retire,
  output rename_pkg::tag_t                            retire_old_tag
);

  import rename_pkg::*;

  logic dispatch_fire;  // accepted dispatch
  logic pr_full;
  logic rob_full;
  logic head_done;
  tag_t old_tag;        // map -> rob

  rename_control u_control (
    .dispatch_valid (dispatch_valid),
    .pr_full        (pr_full),
    .rob_full       (rob_full),
    .head_done      (head_done),
    .stall          (stall),
    .dispatch_fire  (dispatch_fire),
    .retire         (retire)
  );

  pr_file u_pr_file (
    .clock           (clock),
    .reset           (reset),
    .dispatch_fire   (dispatch_fire),
    .complete_valid  (complete_valid),
    .complete_tag    (complete_tag),
    .complete_result (complete_result),
    .retire          (retire),
    .retire_old_tag  (retire_old_tag),  // rob head frees its old tag here
    .read_tag1       (read_tag1),
    .read_tag2       (read_tag2),
    .read_value1     (read_value1),
    .read_value2     (read_value2),
    .alloc_tag       (alloc_tag),
    .pr_full         (pr_full)
  );

  map_table u_map_table (
    .clock         (clock),
    .reset         (reset),
    .dispatch_fire (dispatch_fire),
    .dest_arch     (dest_arch),
    .src1_arch     (src1_arch),
    .src2_arch     (src2_arch),
    .alloc_tag     (alloc_tag),
    .src1_tag      (src1_tag),
    .src2_tag      (src2_tag),
    .old_tag       (old_tag)
  );

  reorder_buffer u_rob (
    .clock          (clock),
    .reset          (reset),
    .dispatch_fire  (dispatch_fire),
    .alloc_tag      (alloc_tag),
    .old_tag        (old_tag),
    .complete_valid (complete_valid),
    .complete_rob   (complete_rob),
    .retire         (retire),
    .dispatch_rob   (dispatch_rob),
    .retire_old_tag (retire_old_tag),
    .head_done      (head_done),
    .rob_full       (rob_full)
  );

endmodule

//--- verification/rename_assert.sv
// rule checks bound into rename_top; occupancy and busy tags are tracked here from the strobes
`timescale 1ns/10ps

module rename_assert (
  input logic              clock,
  input logic              reset,
  input logic              dispatch_fire,
  input logic              retire,
  input logic              stall,
  input rename_pkg::tag_t  alloc_tag,
  input rename_pkg::tag_t  retire_old_tag
);

  import rename_pkg::*;

  int unsigned       fail_count = 0;  // read by the testbench
  rob_cnt_t          occupancy;       // instructions in flight
  logic [num_pr-1:0] busy;            // tags holding a mapping
  logic [num_pr-1:0] busy_next;

  always_ff @(posedge clock) begin
    if (reset) begin
      occupancy <= '0;
    end else if (dispatch_fire && !retire) begin
      occupancy <= occupancy + rob_cnt_t'(1);
    end else if (retire && !dispatch_fire) begin
      occupancy <= occupancy - rob_cnt_t'(1);
    end
  end

  always_comb begin
    busy_next = busy;
    if (retire) busy_next[retire_old_tag] = 1'b0;
    if (dispatch_fire) busy_next[alloc_tag] = 1'b1;  // taken by new dest
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= ~free_at_reset;
    end else begin
      busy <= busy_next;
    end
  end

  // every tag busy or every slot taken, from the tracked state
  stall_follows_full: assert property (@(posedge clock) disable iff (reset)
    stall == ((&busy) || (occupancy == rob_cnt_t'(num_rob))))
    else begin
      $error("stall differs from the tracked tag and slot occupancy");
      fail_count++;
    end

  retire_needs_entry: assert property (@(posedge clock) disable iff (reset)
    retire |-> (occupancy != '0))
    else begin
      $error("retire on an empty reorder buffer");
      fail_count++;
    end

  alloc_is_free: assert property (@(posedge clock) disable iff (reset)
    !stall |-> !busy[alloc_tag])
    else begin
      $error("alloc_tag offers a tag still in use");
      fail_count++;
    end

endmodule

bind rename_top rename_assert u_assert (
  .clock          (clock),
  .reset          (reset),
  .dispatch_fire  (dispatch_fire),
  .retire         (retire),
  .stall          (stall),
  .alloc_tag      (alloc_tag),
  .retire_old_tag (retire_old_tag)
);

//--- verification/rename_tb.sv
// rename core testbench; reference model of map, free list, values and rob order, random completion order
`timescale 1ns/10ps

module rename_tb;

  import rename_pkg::*;

  localparam int clock_period    = 40;   // ns
  localparam int watchdog_cycles = 600;  // longer than all phases together

  // in-flight instruction as the model sees it
  typedef struct {
    rob_idx_t rob;
    tag_t     new_tag;
    tag_t     old_tag;
    logic     done;
  } flight_t;

  logic                     clock;
  logic                     reset;
  logic                     dispatch_valid;
  arch_t                    dest_arch;
  arch_t                    src1_arch;
  arch_t                    src2_arch;
  logic                     complete_valid;
  tag_t                     complete_tag;
  rob_idx_t                 complete_rob;
  data_t                    complete_result;
  tag_t  [num_fu-1:0]       read_tag1;
  tag_t  [num_fu-1:0]       read_tag2;
  data_t [num_fu-1:0]       read_value1;
  data_t [num_fu-1:0]       read_value2;
  logic                     stall;
  tag_t                     alloc_tag;
  tag_t                     src1_tag;
  tag_t                     src2_tag;
  rob_idx_t                 dispatch_rob;
  logic                     retire;
  tag_t                     retire_old_tag;

  // reference model state
  tag_t              map_m [num_arch];
  logic [num_pr-1:0] free_m;
  data_t             val_m [num_pr];
  rob_idx_t          tail_m;
  flight_t           inflight [$];  // program order, head first

  rename_top uut (.*);

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin : watchdog
    #(watchdog_cycles * clock_period);
    $display("Error at %0t ns: run did not finish within %0d cycles", $time, watchdog_cycles);
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // lowest numbered free tag in the model
  function automatic tag_t lowest_free();
    for (int i = 0; i < num_pr; i++) begin
      if (free_m[i]) return tag_t'(i);
    end
    return '0;
  endfunction

  function automatic logic model_stall();
    return (free_m == '0) || (inflight.size() == num_rob);
  endfunction

  // stored value, or the result on the writeback bus this cycle
  function automatic data_t expected_read(input tag_t t);
    if (complete_valid && (complete_tag == t)) return complete_result;
    return val_m[t];
  endfunction

  // random not-yet-done entry, -1 if none
  function automatic int choose_pending();
    int open_idx [$];
    for (int i = 0; i < inflight.size(); i++) begin
      if (!inflight[i].done) open_idx.push_back(i);
    end
    if (open_idx.size() == 0) return -1;
    return open_idx[$urandom_range(open_idx.size() - 1)];
  endfunction

  task automatic check_outputs();
    logic exp_retire;
    exp_retire = (inflight.size() != 0) && inflight[0].done;
    compare("stall", stall, model_stall());
    if (free_m != '0) compare("alloc_tag", alloc_tag, lowest_free());
    compare("src1_tag", src1_tag, map_m[src1_arch]);  // identity right after reset
    compare("src2_tag", src2_tag, map_m[src2_arch]);
    compare("dispatch_rob", dispatch_rob, tail_m);
    compare("retire", retire, exp_retire);
    if (exp_retire) compare("retire_old_tag", retire_old_tag, inflight[0].old_tag);
    for (int f = 0; f < num_fu; f++) begin
      compare($sformatf("read_value1[%0d]", f), read_value1[f], expected_read(read_tag1[f]));
      compare($sformatf("read_value2[%0d]", f), read_value2[f], expected_read(read_tag2[f]));
    end
    assert (uut.u_assert.fail_count == 0) else begin
      $display("Error at %0t ns: a bound assertion on the rename core failed", $time);
      $display("RESULT: FAIL");
      $fatal(1, "assertion failure");
    end
  endtask

  // model state after the coming edge
  task automatic update_model(input int pick);
    tag_t    a;
    logic    fire;
    logic    ret;
    flight_t item;
    a    = lowest_free();
    fire = dispatch_valid && !model_stall();  // stalled dispatch changes nothing
    ret  = (inflight.size() != 0) && inflight[0].done;
    if (pick >= 0) begin
      val_m[complete_tag]  = complete_result;
      inflight[pick].done = 1'b1;
    end
    if (ret) begin
      free_m[inflight[0].old_tag] = 1'b1;  // old mapping released
      void'(inflight.pop_front());
    end
    if (fire) begin
      free_m[a]    = 1'b0;
      item.rob     = tail_m;
      item.new_tag = a;
      item.old_tag = map_m[dest_arch];  // previous mapping of dest
      item.done    = 1'b0;
      inflight.push_back(item);
      map_m[dest_arch] = a;
      tail_m = (tail_m == rob_idx_t'(num_rob - 1)) ? '0 : tail_m + rob_idx_t'(1);
    end
  endtask

  // drive on the rising edge, check at the falling edge
  task automatic run_cycle(input logic want_dispatch, input logic want_complete);
    int                 pick;
    tag_t [num_fu-1:0]  r1;
    tag_t [num_fu-1:0]  r2;
    @(posedge clock);
    pick = want_complete ? choose_pending() : -1;
    for (int f = 0; f < num_fu; f++) begin
      r1[f] = tag_t'($urandom_range(num_pr - 1));
      r2[f] = tag_t'($urandom_range(num_pr - 1));
    end
    dispatch_valid <= want_dispatch;
    dest_arch      <= arch_t'($urandom_range(num_arch - 1));
    src1_arch      <= arch_t'($urandom_range(num_arch - 1));
    src2_arch      <= arch_t'($urandom_range(num_arch - 1));
    complete_valid <= (pick >= 0);
    if (pick >= 0) begin
      complete_tag <= inflight[pick].new_tag;
      complete_rob <= inflight[pick].rob;
      r2[0] = inflight[pick].new_tag;  // exercises the bypass
    end
    complete_result <= {$urandom, $urandom};
    read_tag1       <= r1;
    read_tag2       <= r2;
    @(negedge clock);
    check_outputs();
    update_model(pick);
  endtask

  initial begin
    void'($urandom(32'h315f));
    reset           = 1'b1;
    dispatch_valid  = 1'b0;
    dest_arch       = '0;
    src1_arch       = '0;
    src2_arch       = '0;
    complete_valid  = 1'b0;
    complete_tag    = '0;
    complete_rob    = '0;
    complete_result = '0;
    read_tag1       = '0;
    read_tag2       = '0;
    for (int i = 0; i < num_arch; i++) map_m[i] = tag_t'(i);
    for (int i = 0; i < num_pr; i++) begin
      free_m[i] = (i >= num_arch);  // low tags hold the reset map
      val_m[i]  = '0;
    end
    tail_m = '0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    repeat (12) run_cycle(1'b1, 1'b0);  // fill up until stall, then hold
    repeat (400) run_cycle($urandom_range(99) < 70, $urandom_range(1));
    while (inflight.size() != 0) run_cycle(1'b0, 1'b1);  // drain
    repeat (4) run_cycle(1'b0, 1'b0);
    if (uut.u_assert.fail_count != 0) begin
      $display("RESULT: FAIL");
      $fatal(1, "assertion failure");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- all.f
common/rename_pkg.sv
pr_file/pr_file.sv
map_table/map_table.sv
reorder_buffer/reorder_buffer.sv
verilog/rename_control.sv
verilog/rename_top.sv
verification/rename_assert.sv
verification/rename_tb.sv
